/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int WORD_W     = 32;
  localparam int INSTR_W    = 16;
  localparam int MEM_ADDR_W = 18;  // Halfword address
  localparam int REG_ADDR_W = 4;
  localparam int DBG_W      = 64;

  localparam logic [REG_ADDR_W-1:0] PC_REG = 4'd15;

  typedef enum logic [3:0] {
    FETCH0,
    FETCH1,
    DECODE1,
    DECODE2,     // A read for ALU, shift and branch
    DECODE3,     // D read for port transfer
    EXEC1,
    EXEC_JUMP,
    EXEC_SHIFT,
    EXEC_PORT
  } core_state_e;

  // Top nibble of the instruction
  typedef enum logic [3:0] {
    OP_ADD   = 4'b0000,
    OP_SUB   = 4'b0001,
    OP_XOR   = 4'b0010,
    OP_AND   = 4'b0011,
    OP_ORR   = 4'b0100,
    OP_SHF   = 4'b0101,
    OP_CONST = 4'b1010,
    OP_BEQ   = 4'b1011,
    OP_BLT   = 4'b1100,
    OP_BLE   = 4'b1101,
    OP_BLTS  = 4'b1110,
    OP_EXT   = 4'b1111   // Sub-op in bits 11..8
  } opcode_e;

  typedef enum logic [7:0] {
    CMD_STATUS = 8'd0,
    CMD_HALT   = 8'd1,
    CMD_RESUME = 8'd2
  } dbg_cmd_e;

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  wire  [WORD_W-1:0] op_a,
  input  wire  [WORD_W-1:0] op_b,
  input  var   opcode_e     opcode,
  output logic [WORD_W-1:0] alu_result,
  output logic              branch_taken
);

  always_comb begin
    alu_result   = '0;
    branch_taken = 1'b0;

    case (opcode)
      OP_ADD: alu_result = op_a + op_b;
      OP_SUB: alu_result = op_a - op_b;
      OP_XOR: alu_result = op_a ^ op_b;
      OP_AND: alu_result = op_a & op_b;
      OP_ORR: alu_result = op_a | op_b;

      // Branch conditions, A against B
      OP_BEQ:  branch_taken = op_a == op_b;
      OP_BLT:  branch_taken = op_a < op_b;
      OP_BLE:  branch_taken = op_a <= op_b;
      OP_BLTS: branch_taken = $signed(op_a) < $signed(op_b);

      default: begin
        alu_result   = '0;  // Shift, const and ext handled in the core
        branch_taken = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [REG_ADDR_W-1:0] rf_addr,
  input  wire                   rf_write,
  input  wire  [WORD_W-1:0]     rf_wdata,
  output logic [WORD_W-1:0]     rf_rdata
);

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  logic [WORD_W-1:0] regs [NUM_REGS];  // Entry 15 is the PC

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end else if (rf_write) begin
      regs[rf_addr] <= rf_wdata;
    end
  end

  assign rf_rdata = regs[rf_addr];

  a_addr_known: assert property (@(posedge clk) disable iff (rst)
    rf_write |-> !$isunknown(rf_addr));

endmodule

`default_nettype wire

/* design/debug_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_ctrl import cpu_pkg::*; #(
  parameter logic [7:0] DBG_ADDR = 8'd3
) (
  input  wire               clk,
  input  wire               rst,
  input  wire  [7:0]        dbg_addr,
  input  wire               dbg_start,
  input  wire  [DBG_W-1:0]  dbg_wdata,
  output logic [DBG_W-1:0]  dbg_rdata,
  output logic              dbg_available,
  output logic              dbg_accepted,
  output logic              hlt_req,
  input  wire               hlt_state
);

  typedef enum logic [1:0] {
    IDLE,
    RESPOND,
    DONE
  } dbg_state_e;

  dbg_state_e state;
  dbg_cmd_e   cmd;
  dbg_cmd_e   new_cmd;
  logic       selected;
  logic       ready;
  logic       resp_bit;

  assign selected = dbg_start && dbg_addr == DBG_ADDR;
  assign new_cmd  = dbg_cmd_e'(dbg_wdata[7:0]);

  // Halt and resume wait for the core to catch up
  always_comb begin
    case (cmd)
      CMD_STATUS: begin
        ready    = 1'b1;
        resp_bit = hlt_state;
      end
      CMD_HALT: begin
        ready    = hlt_state;
        resp_bit = 1'b1;
      end
      CMD_RESUME: begin
        ready    = !hlt_state;
        resp_bit = 1'b1;
      end
      default: begin
        ready    = 1'b1;  // Unknown command answers 0
        resp_bit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      dbg_accepted  <= 1'b0;
      dbg_available <= 1'b0;
      dbg_rdata     <= '0;
      hlt_req       <= 1'b1;  // Come up halted
    end else begin
      dbg_accepted  <= 1'b0;
      dbg_available <= 1'b0;

      case (state)
        IDLE: begin
          if (selected) begin
            dbg_accepted <= 1'b1;
            cmd          <= new_cmd;
            state        <= RESPOND;
            if (new_cmd == CMD_HALT)
              hlt_req <= 1'b1;
            else if (new_cmd == CMD_RESUME)
              hlt_req <= 1'b0;
          end
        end
        RESPOND: begin
          if (ready) begin
            dbg_available <= 1'b1;
            dbg_rdata     <= {{(DBG_W-1){1'b0}}, resp_bit};
            state         <= DONE;
          end
        end
        default: begin
          dbg_rdata <= '0;
          state     <= IDLE;
        end
      endcase
    end
  end

  a_acc_avail_apart: assert property (@(posedge clk) disable iff (rst)
    !(dbg_accepted && dbg_available));

endmodule

`default_nettype wire

/* design/core_control.sv */
`timescale 1ns/1ps
`default_nettype none

module core_control import cpu_pkg::*; (
  input  wire                   clk,
  input  wire                   rst,

  output logic [REG_ADDR_W-1:0] rf_addr,
  output logic                  rf_write,
  output logic [WORD_W-1:0]     rf_wdata,
  input  wire  [WORD_W-1:0]     rf_rdata,

  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic                  mem_req,
  input  wire                   mem_ack,
  input  wire  [INSTR_W-1:0]    mem_rdata,

  output logic [7:0]            port_addr,
  output logic                  port_req,
  output logic [WORD_W-1:0]     port_wdata,
  input  wire                   port_ack,
  input  wire  [WORD_W-1:0]     port_rdata,

  output logic [WORD_W-1:0]     op_a,
  output logic [WORD_W-1:0]     op_b,
  output opcode_e               opcode,
  input  wire  [WORD_W-1:0]     alu_result,
  input  wire                   branch_taken,

  input  wire                   hlt_req,
  output logic                  hlt_state
);

  localparam logic [3:0] EXT_PORT = 4'b0110;  // Port transfer under OP_EXT

  core_state_e        state;
  logic [INSTR_W-1:0] instr;
  logic [WORD_W-1:0]  reg_a;
  logic [WORD_W-1:0]  shf_cnt;

  opcode_e            fetch_op;
  logic               fetch_port;
  logic               is_port;
  logic [WORD_W-1:0]  shf_amt;
  logic               shf_done;
  logic [WORD_W-1:0]  shf_next_a;
  logic [WORD_W-1:0]  shf_next_cnt;

  assign fetch_op   = opcode_e'(mem_rdata[15:12]);
  assign fetch_port = mem_rdata[11:8] == EXT_PORT;
  assign opcode     = opcode_e'(instr[15:12]);
  assign is_port    = instr[11:8] == EXT_PORT;

  assign op_a = reg_a;
  assign op_b = rf_rdata;  // B sits on the register port in EXEC1

  // Amount from B on the first step, then from the counter
  assign shf_amt      = (state == EXEC_SHIFT) ? shf_cnt : rf_rdata;
  assign shf_done     = shf_amt == '0;
  assign shf_next_a   = shf_amt[WORD_W-1] ? reg_a >> 1 : reg_a << 1;
  assign shf_next_cnt = shf_amt[WORD_W-1] ? shf_amt + 1'b1 : shf_amt - 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= FETCH0;
      rf_addr   <= PC_REG;
      rf_write  <= 1'b0;
      mem_req   <= 1'b0;
      port_req  <= 1'b0;
      hlt_state <= 1'b1;
    end else begin
      rf_write <= 1'b0;
      port_req <= 1'b0;

      case (state)
        FETCH0: begin
          rf_addr   <= PC_REG;
          hlt_state <= hlt_req;  // Halt only lands between instructions
          if (!hlt_req)
            state <= FETCH1;
        end

        FETCH1: begin
          mem_addr <= rf_rdata[MEM_ADDR_W:1];
          mem_req  <= 1'b1;
          rf_addr  <= PC_REG;
          rf_wdata <= rf_rdata + WORD_W'(2);
          rf_write <= 1'b1;
          state    <= DECODE1;
        end

        DECODE1: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            instr   <= mem_rdata;
            case (fetch_op)
              OP_CONST: begin
                rf_addr  <= mem_rdata[3:0];
                rf_wdata <= {{(WORD_W-8){1'b0}}, mem_rdata[11:4]};
                rf_write <= 1'b1;
                state    <= FETCH0;
              end
              OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_ORR, OP_SHF,
              OP_BEQ, OP_BLT, OP_BLE, OP_BLTS: begin
                rf_addr <= mem_rdata[11:8];
                state   <= DECODE2;
              end
              OP_EXT: begin
                rf_addr <= mem_rdata[3:0];  // D carries the port address
                state   <= fetch_port ? DECODE3 : FETCH0;
              end
              default: state <= FETCH0;  // Unused opcodes are no-ops
            endcase
          end
        end

        DECODE2, DECODE3: begin
          reg_a   <= rf_rdata;
          rf_addr <= instr[7:4];
          state   <= EXEC1;
        end

        EXEC1: begin
          case (opcode)
            OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_ORR: begin
              rf_addr  <= instr[3:0];
              rf_wdata <= alu_result;
              rf_write <= 1'b1;
              state    <= FETCH0;
            end
            OP_SHF: begin
              if (shf_done) begin
                rf_addr  <= instr[3:0];
                rf_wdata <= reg_a;
                rf_write <= 1'b1;
                state    <= FETCH0;
              end else begin
                reg_a   <= shf_next_a;
                shf_cnt <= shf_next_cnt;
                state   <= EXEC_SHIFT;
              end
            end
            OP_BEQ, OP_BLT, OP_BLE, OP_BLTS: begin
              rf_addr <= instr[3:0];  // Target lives in D
              state   <= branch_taken ? EXEC_JUMP : FETCH0;
            end
            OP_EXT: begin
              if (is_port) begin
                port_addr  <= reg_a[7:0];
                port_wdata <= rf_rdata;
                port_req   <= 1'b1;
                state      <= EXEC_PORT;
              end else begin
                state <= FETCH0;
              end
            end
            default: state <= FETCH0;
          endcase
        end

        EXEC_JUMP: begin
          rf_addr  <= PC_REG;
          rf_wdata <= rf_rdata;
          rf_write <= 1'b1;
          state    <= FETCH0;
        end

        EXEC_SHIFT: begin
          if (shf_done) begin
            rf_addr  <= instr[3:0];
            rf_wdata <= reg_a;
            rf_write <= 1'b1;
            state    <= FETCH0;
          end else begin
            reg_a   <= shf_next_a;
            shf_cnt <= shf_next_cnt;
          end
        end

        EXEC_PORT: begin
          if (port_ack) begin
            rf_addr  <= instr[7:4];  // Reply goes back into B
            rf_wdata <= port_rdata;
            rf_write <= 1'b1;
            state    <= FETCH0;
          end
        end

        default: state <= FETCH0;
      endcase
    end
  end

  // A fetch never starts while the debugger sees the core halted
  a_no_fetch_halted: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !hlt_state);

  a_port_pulse: assert property (@(posedge clk) disable iff (rst)
    port_req |=> !port_req);

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter logic [7:0] DBG_ADDR = 8'd3
) (
  input  wire                   clk,
  input  wire                   rst,

  input  wire  [7:0]            dbg_addr,
  input  wire                   dbg_start,
  input  wire  [DBG_W-1:0]      dbg_wdata,
  output logic [DBG_W-1:0]      dbg_rdata,
  output logic                  dbg_available,
  output logic                  dbg_accepted,

  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic                  mem_req,
  input  wire                   mem_ack,
  input  wire  [INSTR_W-1:0]    mem_rdata,

  output logic [7:0]            port_addr,
  output logic                  port_req,
  output logic [WORD_W-1:0]     port_wdata,
  input  wire                   port_ack,
  input  wire  [WORD_W-1:0]     port_rdata
);

  logic [REG_ADDR_W-1:0] rf_addr;
  logic                  rf_write;
  logic [WORD_W-1:0]     rf_wdata;
  logic [WORD_W-1:0]     rf_rdata;

  logic [WORD_W-1:0]     op_a;
  logic [WORD_W-1:0]     op_b;
  opcode_e               opcode;
  logic [WORD_W-1:0]     alu_result;
  logic                  branch_taken;

  logic                  hlt_req;
  logic                  hlt_state;

  core_control u_core_control (
    .clk          (clk),
    .rst          (rst),
    .rf_addr      (rf_addr),
    .rf_write     (rf_write),
    .rf_wdata     (rf_wdata),
    .rf_rdata     (rf_rdata),
    .mem_addr     (mem_addr),
    .mem_req      (mem_req),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .port_addr    (port_addr),
    .port_req     (port_req),
    .port_wdata   (port_wdata),
    .port_ack     (port_ack),
    .port_rdata   (port_rdata),
    .op_a         (op_a),
    .op_b         (op_b),
    .opcode       (opcode),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .hlt_req      (hlt_req),
    .hlt_state    (hlt_state)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rf_addr  (rf_addr),
    .rf_write (rf_write),
    .rf_wdata (rf_wdata),
    .rf_rdata (rf_rdata)
  );

  alu u_alu (
    .op_a         (op_a),
    .op_b         (op_b),
    .opcode       (opcode),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  debug_ctrl #(
    .DBG_ADDR (DBG_ADDR)
  ) u_debug_ctrl (
    .clk           (clk),
    .rst           (rst),
    .dbg_addr      (dbg_addr),
    .dbg_start     (dbg_start),
    .dbg_wdata     (dbg_wdata),
    .dbg_rdata     (dbg_rdata),
    .dbg_available (dbg_available),
    .dbg_accepted  (dbg_accepted),
    .hlt_req       (hlt_req),
    .hlt_state     (hlt_state)
  );

endmodule

`default_nettype wire

/* sim/tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

  localparam logic [7:0] DBG_ADDR  = 8'd3;
  localparam int TIMEOUT_CYCLES    = 20000;
  localparam int MEM_DEPTH         = 1024;
  localparam int MAX_XFER          = 32;
  localparam int MAX_FETCH         = 256;

  logic                  clk       = 1'b0;
  logic                  rst       = 1'b1;
  logic [7:0]            dbg_addr  = '0;
  logic                  dbg_start = 1'b0;
  logic [DBG_W-1:0]      dbg_wdata = '0;
  logic [DBG_W-1:0]      dbg_rdata;
  logic                  dbg_available;
  logic                  dbg_accepted;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic                  mem_req;
  logic                  mem_ack   = 1'b0;
  logic [INSTR_W-1:0]    mem_rdata = '0;
  logic [7:0]            port_addr;
  logic                  port_req;
  logic [WORD_W-1:0]     port_wdata;
  logic                  port_ack   = 1'b0;
  logic [WORD_W-1:0]     port_rdata = '0;

  // Program image and reference model state
  logic [INSTR_W-1:0] imem [MEM_DEPTH];
  logic [WORD_W-1:0]  m_reg [16];
  int                 fetch_exp [MAX_FETCH];
  logic [7:0]         exp_addr [MAX_XFER];
  logic [WORD_W-1:0]  exp_data [MAX_XFER];
  string              exp_tag [MAX_XFER];
  logic [WORD_W-1:0]  resp_data [MAX_XFER];  // Port replies, drawn up front
  int                 wp;
  int                 n_fetch;
  int                 n_port;
  bit                 taken;

  int               fetch_idx   = 0;
  int               port_idx    = 0;
  int               resp_idx    = 0;
  int               mem_wait    = 0;
  int               port_wait   = 0;
  int               cycle_cnt   = 0;
  bit               port_busy   = 1'b0;
  bit               mem_req_q   = 1'b0;
  bit               core_halted = 1'b1;  // Core comes up halted
  logic [DBG_W-1:0] dbg_exp     = '0;
  string            test_name   = "reset";

  cpu_top #(
    .DBG_ADDR (DBG_ADDR)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .dbg_addr      (dbg_addr),
    .dbg_start     (dbg_start),
    .dbg_wdata     (dbg_wdata),
    .dbg_rdata     (dbg_rdata),
    .dbg_available (dbg_available),
    .dbg_accepted  (dbg_accepted),
    .mem_addr      (mem_addr),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .port_addr     (port_addr),
    .port_req      (port_req),
    .port_wdata    (port_wdata),
    .port_ack      (port_ack),
    .port_rdata    (port_rdata)
  );

  always #4 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    $display(">>> FAIL");
    $fatal(1, "Check failed");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Run stopped");
  endtask

  // Place one instruction and run it on the model
  task automatic put(input logic [15:0] instr);
    logic [3:0]        a;
    logic [3:0]        b;
    logic [3:0]        d;
    logic [WORD_W-1:0] va;
    logic [WORD_W-1:0] vb;
    opcode_e           op;
    int                amt;
    a  = instr[11:8];
    b  = instr[7:4];
    d  = instr[3:0];
    va = m_reg[a];
    vb = m_reg[b];
    op = opcode_e'(instr[15:12]);
    imem[wp] = instr;
    fetch_exp[n_fetch] = wp;
    n_fetch++;
    wp++;
    taken = 1'b0;
    case (op)
      OP_ADD:   m_reg[d] = va + vb;
      OP_SUB:   m_reg[d] = va - vb;
      OP_XOR:   m_reg[d] = va ^ vb;
      OP_AND:   m_reg[d] = va & vb;
      OP_ORR:   m_reg[d] = va | vb;
      OP_SHF: begin
        amt = $signed(vb);
        if (amt >= 0)
          m_reg[d] = va << amt;
        else
          m_reg[d] = va >> (-amt);  // Negative amount shifts right
      end
      OP_CONST: m_reg[d] = WORD_W'(instr[11:4]);
      OP_BEQ:   taken = va == vb;
      OP_BLT:   taken = va < vb;
      OP_BLE:   taken = va <= vb;
      OP_BLTS:  taken = $signed(va) < $signed(vb);
      OP_EXT: begin
        if (a == 4'b0110) begin
          exp_addr[n_port] = m_reg[d][7:0];
          exp_data[n_port] = vb;
          m_reg[b]         = resp_data[n_port];  // Reply lands in B
          n_port++;
        end
      end
      default: ;
    endcase
  endtask

  task automatic skip(input logic [15:0] instr);
    imem[wp] = instr;
    wp++;
  endtask

  task automatic load(input logic [3:0] d, input logic [7:0] value);
    put({OP_CONST, value, d});
  endtask

  task automatic alu_op(input opcode_e op, input logic [3:0] d, a, b);
    put({op, a, b, d});
  endtask

  // Negative values built as 0 - n through r5
  task automatic set_reg(input logic [3:0] d, input int value);
    if (value >= 0) begin
      load(d, value[7:0]);
    end else begin
      load(4'd5, 8'(-value));
      alu_op(OP_SUB, d, 4'd0, 4'd5);
    end
  endtask

  task automatic emit(input logic [3:0] b, input string tag);
    exp_tag[n_port] = tag;
    put({OP_EXT, 4'b0110, b, 4'd14});  // r14 holds the port address
  endtask

  task automatic branch_case(input opcode_e op, input int a_val, input int b_val);
    set_reg(4'd1, a_val);
    set_reg(4'd2, b_val);
    load(4'd3, 8'(2 * (wp + 3)));  // Target skips the slot after the branch
    put({op, 4'd1, 4'd2, 4'd3});
    if (taken)
      skip({OP_CONST, 8'hff, 4'd13});
    else
      load(4'd13, 8'h5a);
  endtask

  task automatic build_program();
    opcode_e ops [5] = '{OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_ORR};
    int      x;
    int      y;
    int      k1;
    int      k2;
    for (int i = 0; i < MEM_DEPTH; i++)
      imem[i] = {4'b1000, 2'b00, 10'(i)};  // Unused opcode, runs as no-op
    for (int i = 0; i < 16; i++)
      m_reg[i] = '0;
    for (int i = 0; i < MAX_XFER; i++)
      resp_data[i] = $urandom;
    wp      = 0;
    n_fetch = 0;
    n_port  = 0;
    load(4'd14, 8'($urandom_range(255, 0)));
    x = $urandom_range(100, 1);
    y = $urandom_range(100, 1);
    branch_case(OP_BEQ, x, x);
    branch_case(OP_BEQ, x, x + 1);
    branch_case(OP_BLT, x, x + y);
    branch_case(OP_BLT, x + y, x);
    branch_case(OP_BLE, x, x);
    branch_case(OP_BLE, x + y, x);
    branch_case(OP_BLTS, -x, y);
    branch_case(OP_BLTS, y, -x);
    for (int i = 0; i < 5; i++) begin
      load(4'd1, 8'($urandom_range(255, 0)));
      load(4'd2, 8'($urandom_range(255, 0)));
      alu_op(ops[i], 4'd3, 4'd1, 4'd2);
      emit(4'd3, ops[i].name());
    end
    k1 = $urandom_range(12, 1);
    k2 = $urandom_range(12, 1);
    load(4'd1, 8'($urandom_range(255, 1)));
    load(4'd2, 8'(k1));
    alu_op(OP_SHF, 4'd6, 4'd1, 4'd2);
    set_reg(4'd2, -k2);
    alu_op(OP_SHF, 4'd7, 4'd6, 4'd2);
    load(4'd2, 8'd0);
    alu_op(OP_SHF, 4'd8, 4'd1, 4'd2);
    emit(4'd6, "shift left");
    emit(4'd7, "shift right");
    emit(4'd8, "shift zero");
    load(4'd9, 8'($urandom_range(255, 0)));
    emit(4'd9, "echo out");
    emit(4'd9, "echo back");  // Sends the first reply back
  endtask

  task automatic run_cmd(input string name, input dbg_cmd_e cmd,
                         input logic [DBG_W-1:0] answer);
    test_name = name;
    dbg_exp   = answer;
    @(negedge clk);
    dbg_addr  = DBG_ADDR;
    dbg_wdata = DBG_W'(cmd);
    dbg_start = 1'b1;
    if (cmd == CMD_RESUME)
      core_halted = 1'b0;
    @(negedge clk);
    dbg_start = 1'b0;
    while (!dbg_available)
      @(negedge clk);
    if (cmd == CMD_HALT)
      core_halted = 1'b1;
    @(negedge clk);  // Controller back to idle
  endtask

  always @(negedge clk) begin
    if (mem_ack) begin
      mem_ack <= 1'b0;
    end else if (mem_req) begin
      if (mem_wait == 0) begin
        mem_rdata <= imem[mem_addr[9:0]];
        mem_ack   <= 1'b1;
        mem_wait  <= $urandom_range(3, 0);
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end
  end

  always @(negedge clk) begin
    if (port_ack) begin
      port_ack <= 1'b0;
    end else if (port_req || port_busy) begin
      if (port_wait == 0) begin
        port_ack   <= 1'b1;
        port_rdata <= resp_data[resp_idx];
        resp_idx   <= resp_idx + 1;
        port_busy  <= 1'b0;
        port_wait  <= $urandom_range(3, 0);
      end else begin
        port_busy <= 1'b1;
        port_wait <= port_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      fetch_idx <= 0;
      port_idx  <= 0;
      mem_req_q <= 1'b0;
    end else begin
      mem_req_q <= mem_req;
      if (mem_req && !mem_req_q)
        fetch_idx <= fetch_idx + 1;
      if (port_req)
        port_idx <= port_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_failure("Timeout: the run did not finish within the cycle limit");
  end

  a_dbg_accept: assert property (@(posedge clk) disable iff (rst)
    dbg_start && dbg_addr == DBG_ADDR |=> dbg_accepted)
    else report_failure("Debug command was not accepted one cycle after start");

  a_dbg_ignore: assert property (@(posedge clk) disable iff (rst)
    dbg_start && dbg_addr != DBG_ADDR |=> !dbg_accepted)
    else report_failure("Debug controller took a command for another address");

  a_dbg_answer: assert property (@(posedge clk) disable iff (rst)
    dbg_available |-> dbg_rdata == dbg_exp)
    else report_mismatch(test_name, dbg_exp, $sampled(dbg_rdata));

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    core_halted |-> !mem_req)
    else report_failure("mem_req went high while the core was halted");

  a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) && fetch_idx < n_fetch |-> mem_addr == MEM_ADDR_W'(fetch_exp[fetch_idx]))
    else report_mismatch($sformatf("fetch %0d", $sampled(fetch_idx)),
                         64'(fetch_exp[$sampled(fetch_idx)]), 64'($sampled(mem_addr)));

  a_fetch_end: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) && fetch_idx >= n_fetch |-> mem_addr >= MEM_ADDR_W'(wp))
    else report_failure("Fetch went back into the program after its last instruction");

  a_port_count: assert property (@(posedge clk) disable iff (rst)
    port_req |-> port_idx < n_port)
    else report_failure("Port transfer beyond the expected list");

  a_port_addr: assert property (@(posedge clk) disable iff (rst)
    port_req && port_idx < n_port |-> port_addr == exp_addr[port_idx])
    else report_mismatch($sformatf("%s port_addr", exp_tag[$sampled(port_idx)]),
                         64'(exp_addr[$sampled(port_idx)]), 64'($sampled(port_addr)));

  a_port_data: assert property (@(posedge clk) disable iff (rst)
    port_req && port_idx < n_port |-> port_wdata == exp_data[port_idx])
    else report_mismatch($sformatf("%s port_wdata", exp_tag[$sampled(port_idx)]),
                         64'(exp_data[$sampled(port_idx)]), 64'($sampled(port_wdata)));

  initial begin
    void'($urandom(8));
    build_program();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Start on a foreign address must be ignored
    test_name = "other address";
    dbg_addr  = 8'd5;
    dbg_wdata = DBG_W'(CMD_STATUS);
    dbg_start = 1'b1;
    @(negedge clk);
    dbg_start = 1'b0;
    repeat (4) @(negedge clk);

    run_cmd("reset status", CMD_STATUS, 64'd1);
    run_cmd("resume", CMD_RESUME, 64'd1);
    run_cmd("running status", CMD_STATUS, 64'd0);
    while (port_idx < 4)
      @(negedge clk);
    run_cmd("halt", CMD_HALT, 64'd1);
    repeat (16) @(negedge clk);  // Core must stay quiet here
    run_cmd("halted status", CMD_STATUS, 64'd1);
    run_cmd("resume after halt", CMD_RESUME, 64'd1);
    while (resp_idx < n_port)
      @(negedge clk);
    run_cmd("final halt", CMD_HALT, 64'd1);

    if (fetch_idx < n_fetch) begin
      report_mismatch("fetch count", 64'(n_fetch), 64'(fetch_idx));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/debug_ctrl.sv
design/core_control.sv
design/cpu_top.sv
sim/tb_cpu_top.sv
